//--- sp_pkg.sv
package sp_pkg;

  // Sector geometry
  localparam int NUM_VM        = 4;
  localparam int PROJ_DEPTH    = 128;
  localparam int VM_PAGE_DEPTH = 64;
  localparam int STUB_DEPTH    = 16;

  // Largest accepted |z_proj - z_stub|
  localparam int MATCH_WINDOW  = 2;

  typedef logic [2:0]                          bx_t;
  typedef logic [$clog2(PROJ_DEPTH)-1:0]       proj_index_t;
  typedef logic [$clog2(VM_PAGE_DEPTH)-1:0]    vm_addr_t;
  typedef logic [$clog2(NUM_VM)-1:0]           vm_sel_t;
  typedef logic [5:0]                          zbin_t;
  typedef logic [$clog2(STUB_DEPTH)-1:0]       stub_index_t;
  typedef logic [$clog2(STUB_DEPTH+1)-1:0]     stub_count_t;
  typedef logic [7:0]                          cm_addr_t;

  // Word from the projection input memory
  typedef struct packed {
    proj_index_t index;
    vm_sel_t     vm;
    zbin_t       z;
  } proj_t;

  // VM field is implied by which memory holds the word
  typedef struct packed {
    proj_index_t index;
    zbin_t       z;
  } vmproj_t;

  typedef struct packed {
    zbin_t z;
  } stub_t;

  typedef struct packed {
    proj_index_t proj_index;
    stub_index_t stub_index;
  } cand_match_t;

  // Write side of a two-page VM projection memory
  typedef struct packed {
    logic        wr_en;
    logic        page;
    vm_addr_t    addr;
    vmproj_t     data;
    logic        nent_we;
    proj_index_t nent;
  } vmproj_wr_t;

  // Candidate-match write port
  typedef struct packed {
    logic        wr_en;
    cm_addr_t    addr;
    cand_match_t data;
  } cm_wr_t;

  typedef enum logic [1:0] {
    PR_IDLE,
    PR_READ,
    PR_DRAIN
  } pr_state_t;

  typedef enum logic [2:0] {
    ME_IDLE,
    ME_COUNT,
    ME_FETCH_PROJ,
    ME_SCAN,
    ME_NEXT
  } me_state_t;

endpackage

//--- vmproj_memory.sv
module vmproj_memory (
  input  logic                clk,
  input  logic                reset,
  input  sp_pkg::vmproj_wr_t  wr,
  input  logic                rd_en,
  input  logic                rd_page,
  input  sp_pkg::vm_addr_t    rd_addr,
  output sp_pkg::vmproj_t     rd_data,
  output sp_pkg::proj_index_t nentries
);
  import sp_pkg::*;

  // Page is the top address bit
  vmproj_t     mem [2*VM_PAGE_DEPTH];
  proj_index_t nent [2];

  always_ff @(posedge clk)
  begin
    if (wr.wr_en)
      mem[{wr.page, wr.addr}] <= wr.data;
    if (rd_en)
      rd_data <= mem[{rd_page, rd_addr}];
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      nent[0] <= '0;
      nent[1] <= '0;
    end
    else if (wr.nent_we)
    begin
      nent[wr.page] <= wr.nent;
    end
  end

  assign nentries = nent[rd_page];

  // A count past the page depth means earlier data writes wrapped
  // onto the start of the page
  assert property (@(posedge clk) disable iff (reset)
    wr.nent_we |-> int'(wr.nent) <= VM_PAGE_DEPTH)
    else $error("VM page overflow, count %0d", wr.nent);

endmodule

//--- projection_router.sv
module projection_router (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  sp_pkg::bx_t         bx,
  input  sp_pkg::proj_index_t nentries,
  output logic                rd_en,
  output sp_pkg::proj_index_t rd_addr,
  input  sp_pkg::proj_t       rd_data,
  output sp_pkg::vmproj_wr_t  vm_wr [sp_pkg::NUM_VM],
  output sp_pkg::bx_t         bx_o,
  output logic                route_done
);
  import sp_pkg::*;

  pr_state_t   state;
  logic        rd_valid;
  logic        accept;
  bx_t         bx_q;
  proj_index_t wr_cnt [NUM_VM];

  assign accept = (state == PR_IDLE) && start;

  // Read sequencer
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= PR_IDLE;
      rd_en    <= 1'b0;
      rd_addr  <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= rd_en;
      case (state)
        PR_IDLE:
        begin
          if (start)
          begin
            state   <= PR_READ;
            rd_en   <= (nentries != '0);
            rd_addr <= '0;
          end
        end
        PR_READ:
        begin
          // Last read data lands in the cycle with rd_en already low
          if (!rd_en)
            state <= PR_DRAIN;
          else if (rd_addr == nentries - 1'b1)
            rd_en <= 1'b0;
          else
            rd_addr <= rd_addr + 1'b1;
        end
        default:
        begin
          state <= PR_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      bx_q <= bx;
  end

  // Next free address per VM and the final entry count
  always_ff @(posedge clk)
  begin
    for (int v = 0; v < NUM_VM; v++)
    begin
      if (reset || accept)
        wr_cnt[v] <= '0;
      else if (vm_wr[v].wr_en)
        wr_cnt[v] <= wr_cnt[v] + 1'b1;
    end
  end

  always_comb
  begin
    for (int v = 0; v < NUM_VM; v++)
    begin
      vm_wr[v].wr_en      = rd_valid && (rd_data.vm == vm_sel_t'(v));
      vm_wr[v].page       = bx_q[0];
      vm_wr[v].addr       = vm_addr_t'(wr_cnt[v]);
      vm_wr[v].data.index = rd_data.index;
      vm_wr[v].data.z     = rd_data.z;
      vm_wr[v].nent_we    = (state == PR_DRAIN);
      vm_wr[v].nent       = wr_cnt[v];
    end
  end

  assign bx_o       = bx_q;
  assign route_done = (state == PR_DRAIN);

  assert property (@(posedge clk) disable iff (reset)
    rd_en |-> state == PR_READ)
    else $error("projection read issued outside READ");

endmodule

//--- match_engine.sv
module match_engine (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  sp_pkg::bx_t         bx,
  output logic                proj_rd_en,
  output logic                proj_rd_page,
  output sp_pkg::vm_addr_t    proj_rd_addr,
  input  sp_pkg::vmproj_t     proj_rd_data,
  input  sp_pkg::proj_index_t proj_nentries,
  output logic                stub_rd_en,
  output sp_pkg::stub_index_t stub_rd_addr,
  input  sp_pkg::stub_t       stub_rd_data,
  input  sp_pkg::stub_count_t stub_nentries,
  output sp_pkg::cm_wr_t      cm_wr,
  output logic                eng_done
);
  import sp_pkg::*;

  me_state_t   state;
  logic        page_q;
  proj_index_t nproj_q;
  proj_index_t proj_cnt;
  stub_count_t nstub_q;
  stub_index_t stub_addr;
  logic        proj_valid;
  logic        stub_valid;
  stub_index_t stub_idx_q;
  vmproj_t     proj_q;
  cm_addr_t    cm_cnt;
  zbin_t       z_diff;
  logic        empty;
  logic        last_stub;
  logic        last_proj;

  assign empty     = (proj_nentries == '0) || (stub_nentries == '0);
  assign last_stub = (stub_count_t'(stub_addr) == nstub_q - 1'b1);
  assign last_proj = (proj_cnt == nproj_q - 1'b1);

  assign proj_rd_en   = (state == ME_FETCH_PROJ);
  assign proj_rd_page = page_q;
  assign proj_rd_addr = vm_addr_t'(proj_cnt);
  assign stub_rd_en   = (state == ME_SCAN);
  assign stub_rd_addr = stub_addr;

  assign eng_done = ((state == ME_COUNT) && empty) || ((state == ME_NEXT) && last_proj);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= ME_IDLE;
      page_q     <= 1'b0;
      proj_valid <= 1'b0;
      stub_valid <= 1'b0;
      nproj_q    <= '0;
      nstub_q    <= '0;
      proj_cnt   <= '0;
      stub_addr  <= '0;
      cm_cnt     <= '0;
    end
    else
    begin
      proj_valid <= proj_rd_en;
      stub_valid <= stub_rd_en;
      if (cm_wr.wr_en)
        cm_cnt <= cm_cnt + 1'b1;
      case (state)
        ME_IDLE:
        begin
          if (start)
          begin
            state  <= ME_COUNT;
            page_q <= bx[0];
            cm_cnt <= '0;
          end
        end
        ME_COUNT:
        begin
          nproj_q  <= proj_nentries;
          nstub_q  <= stub_nentries;
          proj_cnt <= '0;
          state    <= empty ? ME_IDLE : ME_FETCH_PROJ;
        end
        ME_FETCH_PROJ:
        begin
          stub_addr <= '0;
          state     <= ME_SCAN;
        end
        ME_SCAN:
        begin
          stub_addr <= stub_addr + 1'b1;
          if (last_stub)
            state <= ME_NEXT;
        end
        ME_NEXT:
        begin
          // Last stub of this projection is compared here
          proj_cnt <= proj_cnt + 1'b1;
          state    <= last_proj ? ME_IDLE : ME_FETCH_PROJ;
        end
        default:
        begin
          state <= ME_IDLE;
        end
      endcase
    end
  end

  // Projection held for the whole stub scan
  always_ff @(posedge clk)
  begin
    if (proj_valid)
      proj_q <= proj_rd_data;
    stub_idx_q <= stub_addr;
  end

  always_comb
  begin
    if (proj_q.z > stub_rd_data.z)
      z_diff = proj_q.z - stub_rd_data.z;
    else
      z_diff = stub_rd_data.z - proj_q.z;
  end

  always_comb
  begin
    cm_wr.wr_en           = stub_valid && (int'(z_diff) <= MATCH_WINDOW);
    cm_wr.addr            = cm_cnt;
    cm_wr.data.proj_index = proj_q.index;
    cm_wr.data.stub_index = stub_idx_q;
  end

  assert property (@(posedge clk) disable iff (reset)
    cm_wr.wr_en |-> state != ME_IDLE)
    else $error("candidate match written while engine idle");

endmodule

//--- sector_processor.sv
module sector_processor (
  input  logic                clk,
  input  logic                reset,
  input  logic                en_proc,
  input  sp_pkg::bx_t         bx_in,
  output logic                proj_rd_en,
  output sp_pkg::proj_index_t proj_rd_addr,
  input  sp_pkg::proj_t       proj_rd_data,
  input  sp_pkg::proj_index_t proj_nentries,
  output logic                stub_rd_en [sp_pkg::NUM_VM],
  output sp_pkg::stub_index_t stub_rd_addr [sp_pkg::NUM_VM],
  input  sp_pkg::stub_t       stub_rd_data [sp_pkg::NUM_VM],
  input  sp_pkg::stub_count_t stub_nentries [sp_pkg::NUM_VM],
  output sp_pkg::cm_wr_t      cm_wr [sp_pkg::NUM_VM],
  output sp_pkg::bx_t         bx_out,
  output logic                done
);
  import sp_pkg::*;

  vmproj_wr_t        vm_wr [NUM_VM];
  bx_t               route_bx;
  logic              route_done;
  logic [NUM_VM-1:0] eng_done;
  logic [NUM_VM-1:0] finished;
  bx_t               bx_hold;

  projection_router projection_router_inst (
    .clk        (clk),
    .reset      (reset),
    .start      (en_proc),
    .bx         (bx_in),
    .nentries   (proj_nentries),
    .rd_en      (proj_rd_en),
    .rd_addr    (proj_rd_addr),
    .rd_data    (proj_rd_data),
    .vm_wr      (vm_wr),
    .bx_o       (route_bx),
    .route_done (route_done)
  );

  for (genvar v = 0; v < NUM_VM; v++)
  begin : gen_vm
    logic        vm_rd_en;
    logic        vm_rd_page;
    vm_addr_t    vm_rd_addr;
    vmproj_t     vm_rd_data;
    proj_index_t vm_nentries;

    vmproj_memory vmproj_memory_inst (
      .clk      (clk),
      .reset    (reset),
      .wr       (vm_wr[v]),
      .rd_en    (vm_rd_en),
      .rd_page  (vm_rd_page),
      .rd_addr  (vm_rd_addr),
      .rd_data  (vm_rd_data),
      .nentries (vm_nentries)
    );

    match_engine match_engine_inst (
      .clk           (clk),
      .reset         (reset),
      .start         (route_done),
      .bx            (route_bx),
      .proj_rd_en    (vm_rd_en),
      .proj_rd_page  (vm_rd_page),
      .proj_rd_addr  (vm_rd_addr),
      .proj_rd_data  (vm_rd_data),
      .proj_nentries (vm_nentries),
      .stub_rd_en    (stub_rd_en[v]),
      .stub_rd_addr  (stub_rd_addr[v]),
      .stub_rd_data  (stub_rd_data[v]),
      .stub_nentries (stub_nentries[v]),
      .cm_wr         (cm_wr[v]),
      .eng_done      (eng_done[v])
    );
  end

  // Event ends the cycle after the last engine reports
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      finished <= '0;
      done     <= 1'b0;
      bx_hold  <= '0;
    end
    else
    begin
      done <= !route_done && (&(finished | eng_done)) && (|(eng_done & ~finished));
      if (route_done)
      begin
        finished <= '0;
        bx_hold  <= route_bx;
      end
      else
      begin
        finished <= finished | eng_done;
      end
    end
  end

  assign bx_out = route_done ? route_bx : bx_hold;

endmodule

//--- tb_sector_processor.sv
module tb_sector_processor;
  import sp_pkg::*;

  logic        clk;
  logic        reset;
  logic        en_proc;
  bx_t         bx_in;
  logic        proj_rd_en;
  proj_index_t proj_rd_addr;
  proj_t       proj_rd_data;
  proj_index_t proj_nentries;
  logic        stub_rd_en [NUM_VM];
  stub_index_t stub_rd_addr [NUM_VM];
  stub_t       stub_rd_data [NUM_VM];
  stub_count_t stub_nentries [NUM_VM];
  cm_wr_t      cm_wr [NUM_VM];
  bx_t         bx_out;
  logic        done;

  proj_t       proj_mem [PROJ_DEPTH];
  stub_t       stub_mem [NUM_VM][STUB_DEPTH];
  proj_index_t rd_q [$];
  cand_match_t exp_m [NUM_VM][$];
  cand_match_t got_m [NUM_VM][$];
  cm_addr_t    got_a [NUM_VM][$];
  int          fd;
  int          limit = 100;
  int          cycles;
  int          done_cnt = 0;

  sector_processor sector_processor_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Projection and stub memory models answer one cycle late
  always @(posedge clk)
  begin
    if (proj_rd_en)
      proj_rd_data <= proj_mem[proj_rd_addr];
    for (int v = 0; v < NUM_VM; v++)
      if (stub_rd_en[v])
        stub_rd_data[v] <= stub_mem[v][stub_rd_addr[v]];
  end

  always @(negedge clk)
  begin
    if (proj_rd_en === 1'b1)
      rd_q.push_back(proj_rd_addr);
    for (int v = 0; v < NUM_VM; v++)
    begin
      if (cm_wr[v].wr_en === 1'b1)
      begin
        got_m[v].push_back(cm_wr[v].data);
        got_a[v].push_back(cm_wr[v].addr);
      end
    end
    if (done === 1'b1)
      done_cnt++;
  end

  task automatic report_error(string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_match(int v, cand_match_t got, cm_addr_t got_addr,
                             cand_match_t exp, cm_addr_t exp_addr);
    if (got !== exp || got_addr !== exp_addr)
      report_error($sformatf("VM%0d match: got (%0d,%0d) at %0d, expected (%0d,%0d) at %0d",
        v, got.proj_index, got.stub_index, got_addr,
        exp.proj_index, exp.stub_index, exp_addr));
  endtask

  task automatic check_bx(bx_t got, bx_t exp);
    if (got !== exp)
      report_error($sformatf("bx_out at done: got %0d, expected %0d", got, exp));
  endtask

  task automatic check_count(string what, proj_index_t got, proj_index_t exp);
    if (got !== exp)
      report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_idle();
    logic busy;
    busy = (done !== 1'b0) || (proj_rd_en !== 1'b0);
    for (int v = 0; v < NUM_VM; v++)
      busy = busy || (stub_rd_en[v] !== 1'b0) || (cm_wr[v].wr_en !== 1'b0);
    if (busy)
      report_error("strobe not low around reset");
  endtask

  // Reads the next number and skips # comment lines
  task automatic read_num(output int val);
    string tok;
    string rest;
    int    code;
    code = $fscanf(fd, "%s", tok);
    while (code == 1 && tok[0] == "#")
    begin
      code = $fgets(rest, fd);
      code = $fscanf(fd, "%s", tok);
    end
    if (code != 1)
    begin
      $display("Stimulus file sp_stim.txt ended before all events were read");
      $display("Regression failed");
      $fatal(1, "short stimulus file");
    end
    val = tok.atoi();
  endtask

  task automatic load_event(output bx_t bx, output proj_index_t np);
    int          n;
    int          a;
    int          b;
    int          c;
    int          n_proj;
    int          max_stub = 0;
    cand_match_t cm;
    read_num(n);
    bx = bx_t'(n);
    read_num(n_proj);
    np = proj_index_t'(n_proj);
    for (int i = 0; i < n_proj; i++)
    begin
      read_num(a);
      read_num(b);
      read_num(c);
      proj_mem[i].index = proj_index_t'(a);
      proj_mem[i].vm    = vm_sel_t'(b);
      proj_mem[i].z     = zbin_t'(c);
    end
    for (int v = 0; v < NUM_VM; v++)
    begin
      read_num(n);
      stub_nentries[v] = stub_count_t'(n);
      if (n > max_stub)
        max_stub = n;
      for (int s = 0; s < n; s++)
      begin
        read_num(c);
        stub_mem[v][s].z = zbin_t'(c);
      end
      exp_m[v].delete();
      read_num(n);
      for (int m = 0; m < n; m++)
      begin
        read_num(a);
        read_num(b);
        cm.proj_index = proj_index_t'(a);
        cm.stub_index = stub_index_t'(b);
        exp_m[v].push_back(cm);
      end
    end
    limit += (n_proj + 4) + n_proj * (max_stub + 4);
  endtask

  initial
  begin
    cycles = 0;
    while (cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles: done never arrived", cycles);
    $display("Regression failed");
    $fatal(1, "timeout");
  end

  initial
  begin
    bx_t         ev_bx;
    proj_index_t ev_np;
    int          nevents;
    reset         = 1'b1;
    en_proc       = 1'b0;
    bx_in         = '0;
    proj_nentries = '0;
    proj_rd_data  = '0;
    for (int v = 0; v < NUM_VM; v++)
    begin
      stub_nentries[v] = '0;
      stub_rd_data[v]  = '0;
    end
    fd = $fopen("sp_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open stimulus file sp_stim.txt");
      $display("Regression failed");
      $fatal(1, "no stimulus file");
    end
    read_num(nevents);
    repeat (5)
    begin
      @(negedge clk);
      check_idle();
    end
    reset = 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      check_idle();
    end
    for (int ev = 0; ev < nevents; ev++)
    begin
      load_event(ev_bx, ev_np);
      rd_q.delete();
      for (int v = 0; v < NUM_VM; v++)
      begin
        got_m[v].delete();
        got_a[v].delete();
      end
      bx_in         = ev_bx;
      proj_nentries = ev_np;
      en_proc       = 1'b1;
      @(negedge clk);
      en_proc = 1'b0;
      wait (done_cnt > ev);
      check_bx(bx_out, ev_bx);
      check_count("projection reads", proj_index_t'(rd_q.size()), ev_np);
      foreach (rd_q[i])
        check_count("projection read address", rd_q[i], proj_index_t'(i));
      for (int v = 0; v < NUM_VM; v++)
      begin
        check_count($sformatf("VM%0d match count", v), proj_index_t'(got_m[v].size()),
                    proj_index_t'(exp_m[v].size()));
        for (int i = 0; i < exp_m[v].size(); i++)
          check_match(v, got_m[v][i], got_a[v][i], exp_m[v][i], cm_addr_t'(i));
      end
    end
    // Quiet tail catches a stray done pulse
    repeat (5) @(negedge clk);
    check_count("done pulses", proj_index_t'(done_cnt), proj_index_t'(nevents));
    $fclose(fd);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- sp_stim.txt
# Event count, then per event: bx nproj, nproj lines of index vm z, then one line per VM:
# nstub, stub z values, nmatch, then nmatch pairs of projection index and stub index
4
1 6
10 0 20
11 1 5
12 0 40
13 2 0
14 3 63
15 1 8
4 18 23 41 20  3 10 0 10 3 12 2
3 7 2 10  3 11 0 15 0 15 2
2 3 1  1 13 1
1 61  1 14 0
2 3
20 0 30
21 0 31
22 3 10
2 33 28  2 20 1 21 0
2 5 8  0
0  0
3 50 12 9  2 22 1 22 2
3 0
2 20 40  0
0  0
0  0
0  0
4 4
30 1 16
31 2 45
32 1 17
33 0 2
3 0 4 5  2 33 0 33 1
5 14 19 16 20 15  6 30 0 30 2 30 4 32 1 32 2 32 4
0  0
2 7 9  0

//--- src.f
sp_pkg.sv
vmproj_memory.sv
projection_router.sv
match_engine.sv
sector_processor.sv
tb_sector_processor.sv
